//--- Makefile
# Verilator build and run of the pagerank compute unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --top-module tb_pagerank_cu -f sources.f -o tb_pagerank_cu
	./obj_dir/tb_pagerank_cu | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sources.f
+incdir+tests
verilog/cu_pkg.sv
verilog/read_command_if.sv
verilog/fifo.sv
verilog/cu_edge_job_control.sv
verilog/cu_vertex_pagerank.sv
verilog/pagerank_cu_top.sv
tests/tb_pagerank_cu.sv

//--- tests/tb_pagerank_ref.svh
`ifndef TB_PAGERANK_REF_SVH
`define TB_PAGERANK_REF_SVH

//////////////////////
// test vectors
//////////////////////

// random job list over a random edge array
task automatic make_vectors();
	for (int a = 0; a < 256; a++) begin
		edge_mem[a] = vertex_t'($urandom);
	end
	for (int j = 0; j < N_JOBS; j++) begin
		job_id[j]     = vertex_t'($urandom);
		job_start[j]  = edge_addr_t'($urandom % 248);
		job_degree[j] = degree_t'($urandom % 7);
	end
	// one vertex without edges
	job_degree[3] = '0;
endtask

//////////////////////
// reference model
//////////////////////

function automatic int total_edges();
	int sum;
	sum = 0;
	for (int j = 0; j < N_JOBS; j++) begin
		sum += int'(job_degree[j]);
	end
	return sum;
endfunction

// k-th edge job overall, as {source, destination}
function automatic logic [31:0] expected_pair(int k);
	int rest;
	logic [7:0] index;
	rest = k;
	for (int j = 0; j < N_JOBS; j++) begin
		if (rest < int'(job_degree[j])) begin
			index = 8'(job_start[j] + edge_addr_t'(rest));
			return {job_id[j], edge_mem[index]};
		end
		rest -= int'(job_degree[j]);
	end
	return '0;
endfunction

//////////////////////
// checks
//////////////////////

task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
	checks++;
	if (expected !== actual) begin
		errors++;
		$display("[ERROR] %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
	end
endtask

task automatic report_failure(string what);
	errors++;
	$display("%s at %0t", what, $time);
endtask

`endif

//--- tests/tb_pagerank_cu.sv
`timescale 1ns/100ps

module tb_pagerank_cu import cu_pkg::*; ();

	localparam int N_JOBS = 12;

	logic        clock;
	logic        rstn;
	logic        enabled;
	logic        vertex_valid;
	vertex_t     vertex_id;
	edge_addr_t  vertex_edge_start;
	degree_t     vertex_degree;
	logic        vertex_buffer_empty;
	logic        read_data_valid;
	struct_tag_t read_data_tag;
	vertex_t     read_data_vertex;
	logic        read_buffer_full;
	logic        vertex_request;
	logic        read_cmd_valid;
	struct_tag_t read_cmd_tag;
	edge_addr_t  read_cmd_address;
	logic        edge_valid;
	vertex_t     edge_src;
	vertex_t     edge_dest;
	count_t      vertex_num_counter;
	count_t      edge_num_counter;

	vertex_t    job_id [N_JOBS];
	edge_addr_t job_start [N_JOBS];
	degree_t    job_degree [N_JOBS];
	vertex_t    edge_mem [256];

	int errors = 0;
	int checks = 0;
	int cycle = 0;
	int limit = 0;
	int total = 0;
	int tail = 0;
	int seed_value;

	// vertex buffer and memory model
	int job_idx = 0;
	logic answer_pending = 1'b0;
	edge_addr_t pend_addr [$];
	int pend_due [$];
	int last_due = 0;

	// comparer state
	int edge_idx = 0;
	int cmd_count = 0;
	logic busy = 1'b0;
	logic prev_empty = 1'b0;
	logic prev_full = 1'b0;
	logic prev_enabled = 1'b0;
	count_t prev_vcount = '0;
	count_t prev_ecount = '0;
	edge_addr_t cmd_addr = '0;
	edge_addr_t last_addr = '0;
	logic [31:0] pair;

	`include "tb_pagerank_ref.svh"

	pagerank_cu_top i_dut (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// vertex buffer, memory and back-pressure for one cycle
	task automatic drive_models();
		int due;
		enabled          = ((cycle % 37) >= 3);
		read_buffer_full = (($urandom % 4) == 0);
		vertex_valid     = 1'b0;
		if (answer_pending && enabled) begin
			vertex_id         = job_id[job_idx];
			vertex_edge_start = job_start[job_idx];
			vertex_degree     = job_degree[job_idx];
			vertex_valid      = 1'b1;
			job_idx++;
			answer_pending = 1'b0;
		end
		if (vertex_request) begin
			answer_pending = 1'b1;
		end
		vertex_buffer_empty = ((job_idx + int'(answer_pending)) >= N_JOBS);
		// in-order replies, 1 to 4 cycles late
		if (read_cmd_valid) begin
			due = cycle + 1 + int'($urandom % 4);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			pend_addr.push_back(read_cmd_address);
			pend_due.push_back(due);
		end
		read_data_valid = 1'b0;
		read_data_tag   = EDGE_ARRAY_DEST;
		if (enabled && (pend_due.size() > 0) && (pend_due[0] <= cycle)) begin
			read_data_valid  = 1'b1;
			read_data_vertex = edge_mem[pend_addr[0][7:0]];
			void'(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end else if (enabled && (($urandom % 6) == 0)) begin
			// unrelated line, must be dropped
			read_data_valid  = 1'b1;
			read_data_tag    = GRAPH_DATA;
			read_data_vertex = vertex_t'($urandom);
		end
	endtask

	initial begin
		seed_value          = $urandom(46557);
		rstn                = 1'b0;
		enabled             = 1'b0;
		vertex_valid        = 1'b0;
		vertex_id           = '0;
		vertex_edge_start   = '0;
		vertex_degree       = '0;
		vertex_buffer_empty = 1'b0;
		read_data_valid     = 1'b0;
		read_data_tag       = EDGE_ARRAY_DEST;
		read_data_vertex    = '0;
		read_buffer_full    = 1'b0;
		make_vectors();
		total = total_edges();
		limit = 200 + 20 * total;
		repeat (5) @(posedge clock);
		#2;
		check_value("reset vertex_request", 0, 32'(vertex_request));
		check_value("reset read_cmd_valid", 0, 32'(read_cmd_valid));
		check_value("reset edge_valid", 0, 32'(edge_valid));
		check_value("reset vertex_num_counter", 0, 32'(vertex_num_counter));
		check_value("reset edge_num_counter", 0, 32'(edge_num_counter));
		rstn = 1'b1;
		// run until every vertex is done, then a short tail for stray edge jobs
		while (tail < 20) begin
			@(posedge clock);
			#2;
			cycle++;
			drive_models();
			if (vertex_num_counter == count_t'(N_JOBS)) begin
				tail++;
			end
		end
		check_value("final vertex_num_counter", N_JOBS, 32'(vertex_num_counter));
		check_value("final edge_num_counter", total, 32'(edge_num_counter));
		check_value("edge jobs seen", total, edge_idx);
		check_value("read commands seen", total, cmd_count);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		wait ((limit > 0) && (cycle > limit));
		report_failure("timeout, the unit did not finish all vertices");
		$display("%0d checks, %0d errors", checks, errors);
		$display("Errors found");
		$finish;
	end

	//////////////////////
	// comparer
	//////////////////////

	always @(negedge clock) begin
		if (rstn) begin
			if (edge_valid) begin
				if (edge_idx >= total) begin
					report_failure("edge job beyond the expected list");
				end else begin
					pair = expected_pair(edge_idx);
					check_value("edge_src", 32'(pair[31:16]), 32'(edge_src));
					check_value("edge_dest", 32'(pair[15:0]), 32'(edge_dest));
				end
				edge_idx++;
			end
			if (read_cmd_valid) begin
				check_value("read_cmd_address", 32'(cmd_addr), 32'(read_cmd_address));
				check_value("read_cmd_tag", 32'(EDGE_ARRAY_DEST), 32'(read_cmd_tag));
				last_addr = read_cmd_address;
				cmd_addr++;
				cmd_count++;
			end else if (cmd_count > 0) begin
				check_value("held read_cmd_address", 32'(last_addr), 32'(read_cmd_address));
			end
			if (prev_full) begin
				check_value("read_cmd_valid under full", 0, 32'(read_cmd_valid));
			end
			if (vertex_request && (prev_empty || busy)) begin
				report_failure("vertex_request while the buffer is empty or a vertex is busy");
			end
			// counters frozen by a disabled cycle
			if (!prev_enabled) begin
				check_value("disabled vertex count", 32'(prev_vcount), 32'(vertex_num_counter));
				check_value("disabled edge count", 32'(prev_ecount), 32'(edge_num_counter));
			end
			if (vertex_num_counter != prev_vcount) begin
				busy = 1'b0;
			end
			if (enabled && vertex_valid) begin
				busy     = 1'b1;
				cmd_addr = vertex_edge_start;
			end
		end
		prev_empty   = vertex_buffer_empty;
		prev_full    = read_buffer_full;
		prev_enabled = enabled;
		prev_vcount  = vertex_num_counter;
		prev_ecount  = edge_num_counter;
	end

endmodule

//--- verilog/cu_edge_job_control.sv
`timescale 1ns/100ps

module cu_edge_job_control import cu_pkg::*; (
	input  logic       clock,
	input  logic       rstn,
	input  logic       enabled,
	input  logic       start,
	input  vertex_t    vertex_id,
	input  edge_addr_t edge_start,
	input  degree_t    degree,
	input  logic       read_buffer_full,
	read_command_if.source read_command,
	input  logic       data_valid,
	input  vertex_t    data_vertex,
	output logic       edge_valid,
	output vertex_t    edge_src,
	output vertex_t    edge_dest,
	output degree_t    edges_pushed,
	output logic       done
);

	edge_ctrl_state_t state;
	degree_t issue_count;
	logic issue_now;
	logic last_issue;

	// one command per cycle unless the read buffer pushes back
	assign issue_now  = enabled && (state == ISSUE) && !read_buffer_full;
	assign last_issue = (issue_count == degree - degree_t'(1));

	// a vertex without edges finishes straight from idle
	assign done = ((state == IDLE) && start && (degree == '0)) ||
		((state == DRAIN) && (edges_pushed == degree));

	//////////////////////
	// FSM
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= IDLE;
			issue_count <= '0;
		end else if (enabled) begin
			case (state)
				IDLE: begin
					if (start && (degree != '0)) begin
						state       <= ISSUE;
						issue_count <= '0;
					end
				end
				ISSUE: begin
					if (issue_now) begin
						issue_count <= issue_count + 1'b1;
						if (last_issue) begin
							state <= DRAIN;
						end
					end
				end
				DRAIN: begin
					// wait for every returned line of this vertex
					if (done) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//////////////////////
	// read commands
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command.valid <= 1'b0;
		end else begin
			read_command.valid <= issue_now;
		end
	end

	// address holds while stalled
	always_ff @(posedge clock) begin
		if (issue_now) begin
			read_command.address <= edge_start + edge_addr_t'(issue_count);
			read_command.tag     <= EDGE_ARRAY_DEST;
			read_command.vertex  <= vertex_id;
		end
	end

	//////////////////////
	// edge jobs
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_valid   <= 1'b0;
			edges_pushed <= '0;
		end else begin
			edge_valid <= enabled && data_valid;
			if (enabled) begin
				if ((state == IDLE) && start) begin
					edges_pushed <= '0;
				end else if (data_valid) begin
					edges_pushed <= edges_pushed + 1'b1;
				end
			end
		end
	end

	// source is the vertex in flight, destination comes from memory
	always_ff @(posedge clock) begin
		if (enabled && data_valid) begin
			edge_src  <= vertex_id;
			edge_dest <= data_vertex;
		end
	end

endmodule

//--- verilog/cu_pkg.sv
package cu_pkg;

	//////////////////////
	// field widths
	//////////////////////

	localparam int VERTEX_BITS    = 16;
	localparam int EDGE_ADDR_BITS = 16;
	localparam int DEGREE_BITS    = 8;
	localparam int COUNT_BITS     = 16;

	// depth of the returned read data buffer
	localparam int READ_FIFO_DEPTH = 16;

	// request pacing, one vertex request per wrap
	localparam int PULSE_BITS = 3;

	//////////////////////
	// types
	//////////////////////

	typedef logic [VERTEX_BITS-1:0] vertex_t;

	// offset into the edge arrays
	typedef logic [EDGE_ADDR_BITS-1:0] edge_addr_t;

	// out-degree, also the per-vertex edge count
	typedef logic [DEGREE_BITS-1:0] degree_t;

	typedef logic [COUNT_BITS-1:0] count_t;

	// array a read belongs to
	typedef enum logic [2:0] {
		EDGE_ARRAY_SRC,
		EDGE_ARRAY_DEST,
		INV_EDGE_ARRAY_SRC,
		INV_EDGE_ARRAY_DEST,
		GRAPH_DATA
	} struct_tag_t;

	// edge job control FSM
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DRAIN
	} edge_ctrl_state_t;

endpackage

//--- verilog/cu_vertex_pagerank.sv
`timescale 1ns/100ps

module cu_vertex_pagerank import cu_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  logic        vertex_valid,
	input  vertex_t     vertex_id,
	input  edge_addr_t  vertex_edge_start,
	input  degree_t     vertex_degree,
	input  logic        vertex_buffer_empty,
	output logic        vertex_request,
	input  logic        read_data_valid,
	input  struct_tag_t read_data_tag,
	input  vertex_t     read_data_vertex,
	input  logic        read_buffer_full,
	read_command_if.source read_command,
	output logic        edge_valid,
	output vertex_t     edge_src,
	output vertex_t     edge_dest,
	output count_t      vertex_num_counter,
	output count_t      edge_num_counter
);

	localparam int LINE_BITS = $bits(struct_tag_t) + $bits(vertex_t);

	// vertex control
	logic processing;
	logic latch_vertex;
	logic vertex_complete;
	logic vertex_start;
	logic vertex_request_send;
	logic [PULSE_BITS-1:0] request_pulse;
	vertex_t vertex_id_q;
	edge_addr_t edge_start_q;
	degree_t degree_q;
	logic done;

	// read data path
	logic in_valid;
	struct_tag_t in_tag;
	vertex_t in_vertex;
	logic fifo_push;
	logic fifo_pop;
	logic fifo_empty;
	logic [LINE_BITS-1:0] fifo_in;
	logic [LINE_BITS-1:0] fifo_out;
	struct_tag_t out_tag;
	vertex_t out_vertex;
	logic is_dest;
	logic edge_data_valid;
	vertex_t edge_data_vertex;

	assign latch_vertex    = enabled && vertex_valid && !processing;
	assign vertex_complete = enabled && processing && done;

	//////////////////////
	// vertex request
	//////////////////////

	assign vertex_request_send = enabled && !processing && (request_pulse == '0) &&
		!vertex_buffer_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_pulse  <= '0;
			vertex_request <= 1'b0;
		end else begin
			// counter parked at zero while a vertex is busy
			if (processing) begin
				request_pulse <= '0;
			end else begin
				request_pulse <= request_pulse + 1'b1;
			end
			vertex_request <= vertex_request_send;
		end
	end

	//////////////////////
	// vertex latch
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			processing   <= 1'b0;
			vertex_start <= 1'b0;
		end else begin
			if (latch_vertex) begin
				processing <= 1'b1;
			end else if (vertex_complete) begin
				processing <= 1'b0;
			end
			// start survives a disabled cycle
			if (enabled) begin
				vertex_start <= latch_vertex;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (latch_vertex) begin
			vertex_id_q  <= vertex_id;
			edge_start_q <= vertex_edge_start;
			degree_q     <= vertex_degree;
		end
	end

	//////////////////////
	// counters
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			if (vertex_complete) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
			if (enabled && edge_data_valid) begin
				edge_num_counter <= edge_num_counter + 1'b1;
			end
		end
	end

	//////////////////////
	// read data in
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else if (enabled) begin
			in_valid <= read_data_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			in_tag    <= read_data_tag;
			in_vertex <= read_data_vertex;
		end
	end

	assign fifo_push = enabled && in_valid;
	assign fifo_in   = {in_tag, in_vertex};
	assign fifo_pop  = enabled && !fifo_empty;

	fifo #(
		.WIDTH(LINE_BITS),
		.DEPTH(READ_FIFO_DEPTH)
	) i_read_data_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (fifo_push),
		.data_in (fifo_in),
		.pop     (fifo_pop),
		.data_out(fifo_out),
		.full    (),
		.empty   (fifo_empty)
	);

	assign out_tag    = struct_tag_t'(fifo_out[LINE_BITS-1 -: $bits(struct_tag_t)]);
	assign out_vertex = fifo_out[$bits(vertex_t)-1:0];

	// only destination lines build edge jobs, the rest is dropped
	assign is_dest = (out_tag == EDGE_ARRAY_DEST) || (out_tag == INV_EDGE_ARRAY_DEST);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_data_valid <= 1'b0;
		end else if (enabled) begin
			edge_data_valid <= fifo_pop && is_dest;
		end
	end

	always_ff @(posedge clock) begin
		if (fifo_pop) begin
			edge_data_vertex <= out_vertex;
		end
	end

	//////////////////////
	// edge job control
	//////////////////////

	cu_edge_job_control i_edge_job_control (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.start           (vertex_start),
		.vertex_id       (vertex_id_q),
		.edge_start      (edge_start_q),
		.degree          (degree_q),
		.read_buffer_full(read_buffer_full),
		.read_command    (read_command),
		.data_valid      (edge_data_valid),
		.data_vertex     (edge_data_vertex),
		.edge_valid      (edge_valid),
		.edge_src        (edge_src),
		.edge_dest       (edge_dest),
		.edges_pushed    (),
		.done            (done)
	);

endmodule

//--- verilog/fifo.sv
`timescale 1ns/100ps

module fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             empty
);

	localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [ADDR_BITS-1:0] LAST_PTR = ADDR_BITS'(DEPTH - 1);
	localparam logic [ADDR_BITS:0] FULL_COUNT = (ADDR_BITS + 1)'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0] count;
	logic do_push;
	logic do_pop;

	assign full    = (count == FULL_COUNT);
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head of the queue is always visible
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	//////////////////////
	// pointers and fill level
	//////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/pagerank_cu_top.sv
`timescale 1ns/100ps

module pagerank_cu_top import cu_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  logic        vertex_valid,
	input  vertex_t     vertex_id,
	input  edge_addr_t  vertex_edge_start,
	input  degree_t     vertex_degree,
	input  logic        vertex_buffer_empty,
	input  logic        read_data_valid,
	input  struct_tag_t read_data_tag,
	input  vertex_t     read_data_vertex,
	input  logic        read_buffer_full,
	output logic        vertex_request,
	output logic        read_cmd_valid,
	output struct_tag_t read_cmd_tag,
	output edge_addr_t  read_cmd_address,
	output logic        edge_valid,
	output vertex_t     edge_src,
	output vertex_t     edge_dest,
	output count_t      vertex_num_counter,
	output count_t      edge_num_counter
);

	read_command_if read_command ();

	cu_vertex_pagerank i_vertex_pagerank (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.vertex_valid       (vertex_valid),
		.vertex_id          (vertex_id),
		.vertex_edge_start  (vertex_edge_start),
		.vertex_degree      (vertex_degree),
		.vertex_buffer_empty(vertex_buffer_empty),
		.vertex_request     (vertex_request),
		.read_data_valid    (read_data_valid),
		.read_data_tag      (read_data_tag),
		.read_data_vertex   (read_data_vertex),
		.read_buffer_full   (read_buffer_full),
		.read_command       (read_command),
		.edge_valid         (edge_valid),
		.edge_src           (edge_src),
		.edge_dest          (edge_dest),
		.vertex_num_counter (vertex_num_counter),
		.edge_num_counter   (edge_num_counter)
	);

	// command channel out to the memory side
	assign read_cmd_valid   = read_command.valid;
	assign read_cmd_tag     = read_command.tag;
	assign read_cmd_address = read_command.address;

endmodule

//--- verilog/read_command_if.sv
`timescale 1ns/100ps

interface read_command_if import cu_pkg::*; ();

	logic        valid;
	struct_tag_t tag;
	edge_addr_t  address;
	// vertex the command was issued for
	vertex_t     vertex;

	modport source (
		output valid,
		output tag,
		output address,
		output vertex
	);

	// memory side
	modport sink (
		input valid,
		input tag,
		input address,
		input vertex
	);

endinterface
